// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - rtl/ooo_pkg.sv
  - rtl/result_if.sv
  - rtl/operand_station.sv
  - rtl/add_sub_unit.sv
  - rtl/shift_unit.sv
  - rtl/cdb_arbiter.sv
  - rtl/reorder_buffer.sv
  - rtl/ooo_core.sv
  - target: test
    files:
      - verification/ooo_core_props.sv
      - verification/ooo_core_tb.sv

// ==== ooo_core.f ====
rtl/ooo_pkg.sv
rtl/result_if.sv
rtl/operand_station.sv
rtl/add_sub_unit.sv
rtl/shift_unit.sv
rtl/cdb_arbiter.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
verification/ooo_core_props.sv
verification/ooo_core_tb.sv

// ==== rtl/add_sub_unit.sv ====
`timescale 1ns/1ps

module add_sub_unit (
	input logic clk,
	input logic reset,
	input logic load,
	input ooo_pkg::alu_payload_t load_payload,
	input ooo_pkg::cdb_t cdb,
	output logic busy,
	result_if.unit result
);
	ooo_pkg::alu_payload_t payload;
	logic fire;
	logic take;
	logic res_valid;
	logic [ooo_pkg::tag_width-1:0] res_tag;
	logic [ooo_pkg::xlen-1:0] res_data;

	operand_station #(
		.payload_t(ooo_pkg::alu_payload_t)
	) station (
		.clk,
		.reset,
		.load,
		.load_payload,
		.cdb,
		.busy,
		.fire,
		.take,
		.payload
	);

	// output register free or draining this cycle
	assign take = fire && (!res_valid || result.ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else if (take) begin
			res_valid <= 1'b1;
		end else if (result.ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			res_tag <= payload.dst;
			if (payload.op == ooo_pkg::op_sub) begin
				res_data <= payload.a.data - payload.b.data;
			end else begin
				res_data <= payload.a.data + payload.b.data;
			end
		end
	end

	assign result.valid = res_valid;
	assign result.tag = res_tag;
	assign result.data = res_data;
endmodule

// ==== rtl/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
	input logic clk,
	input logic reset,
	result_if.arbiter alu,
	result_if.arbiter shift,
	output ooo_pkg::cdb_t cdb
);
	// set when the shifter had the bus last
	logic last_shift;
	logic grant_alu;
	logic grant_shift;

	assign grant_alu = alu.valid && (!shift.valid || last_shift);
	assign grant_shift = shift.valid && !grant_alu;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_shift <= 1'b0;
		end else if (grant_alu) begin
			last_shift <= 1'b0;
		end else if (grant_shift) begin
			last_shift <= 1'b1;
		end
	end

	assign alu.ready = grant_alu;
	assign shift.ready = grant_shift;

	always_comb begin
		cdb.valid = grant_alu || grant_shift;
		cdb.tag = grant_shift ? shift.tag : alu.tag;
		cdb.data = grant_shift ? shift.data : alu.data;
	end
endmodule

// ==== rtl/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input ooo_pkg::op_t issue_op,
	input logic [ooo_pkg::reg_width-1:0] issue_rd,
	input logic [ooo_pkg::reg_width-1:0] issue_rs1,
	input logic [ooo_pkg::reg_width-1:0] issue_rs2,
	input logic [15:0] issue_imm,
	output logic issue_ready,
	output logic commit_valid,
	output logic [ooo_pkg::reg_width-1:0] commit_rd,
	output logic [ooo_pkg::xlen-1:0] commit_data
);
	logic running;
	logic use_shift;
	logic issue_fire;
	logic rob_full;
	logic alu_busy;
	logic shift_busy;
	logic [ooo_pkg::tag_width-1:0] alloc_tag;
	ooo_pkg::operand_t src1;
	ooo_pkg::operand_t src2;
	ooo_pkg::operand_t imm_operand;
	ooo_pkg::alu_payload_t alu_payload;
	ooo_pkg::shift_payload_t shift_payload;
	ooo_pkg::cdb_t cdb;

	result_if alu_result();
	result_if shift_result();

	//////////////////////////////
	// issue
	//////////////////////////////

	// holds issue off for the first cycle out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	assign use_shift = issue_op == ooo_pkg::op_sll || issue_op == ooo_pkg::op_srl;
	assign issue_ready = running && !rob_full && (use_shift ? !shift_busy : !alu_busy);
	assign issue_fire = issue_valid && issue_ready;

	always_comb begin
		imm_operand.ready = 1'b1;
		imm_operand.tag = '0;
		imm_operand.data = {{(ooo_pkg::xlen-16){issue_imm[15]}}, issue_imm};

		alu_payload.op = issue_op;
		alu_payload.dst = alloc_tag;
		alu_payload.a = src1;
		alu_payload.b = issue_op == ooo_pkg::op_addi ? imm_operand : src2;

		shift_payload.left = issue_op == ooo_pkg::op_sll;
		shift_payload.dst = alloc_tag;
		shift_payload.a = src1;
		shift_payload.b = src2;
	end

	//////////////////////////////
	// rob, units and cdb
	//////////////////////////////

	reorder_buffer rob (
		.clk,
		.reset,
		.alloc(issue_fire),
		.alloc_rd(issue_rd),
		.rs1(issue_rs1),
		.rs2(issue_rs2),
		.alloc_tag,
		.full(rob_full),
		.src1,
		.src2,
		.cdb,
		.commit_valid,
		.commit_rd,
		.commit_data
	);

	add_sub_unit add_sub (
		.clk,
		.reset,
		.load(issue_fire && !use_shift),
		.load_payload(alu_payload),
		.cdb,
		.busy(alu_busy),
		.result(alu_result)
	);

	shift_unit shifter (
		.clk,
		.reset,
		.load(issue_fire && use_shift),
		.load_payload(shift_payload),
		.cdb,
		.busy(shift_busy),
		.result(shift_result)
	);

	cdb_arbiter arbiter (
		.clk,
		.reset,
		.alu(alu_result),
		.shift(shift_result),
		.cdb
	);
endmodule

// ==== rtl/ooo_pkg.sv ====
package ooo_pkg;

	localparam int rob_depth = 8;
	localparam int tag_width = 3;
	localparam int reg_count = 8;
	localparam int reg_width = 3;
	localparam int xlen = 32;

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_addi,
		op_sll,
		op_srl
	} op_t;

	// source operand, data only meaningful once ready
	typedef struct packed {
		logic ready;
		logic [tag_width-1:0] tag;
		logic [xlen-1:0] data;
	} operand_t;

	typedef struct packed {
		op_t op;
		logic [tag_width-1:0] dst;
		operand_t a;
		operand_t b;
	} alu_payload_t;

	// left set for sll, clear for srl
	typedef struct packed {
		logic left;
		logic [tag_width-1:0] dst;
		operand_t a;
		operand_t b;
	} shift_payload_t;

	typedef struct packed {
		logic valid;
		logic [tag_width-1:0] tag;
		logic [xlen-1:0] data;
	} cdb_t;

endpackage

// ==== rtl/operand_station.sv ====
`timescale 1ns/1ps

module operand_station #(
	parameter type payload_t = ooo_pkg::alu_payload_t
) (
	input logic clk,
	input logic reset,
	input logic load,
	input payload_t load_payload,
	input ooo_pkg::cdb_t cdb,
	output logic busy,
	output logic fire,
	input logic take,
	output payload_t payload
);
	logic valid;
	payload_t entry;
	payload_t next_entry;

	// operand wake-up from the cdb
	always_comb begin
		next_entry = load ? load_payload : entry;
		if (cdb.valid && !next_entry.a.ready && next_entry.a.tag == cdb.tag) begin
			next_entry.a.ready = 1'b1;
			next_entry.a.data = cdb.data;
		end
		if (cdb.valid && !next_entry.b.ready && next_entry.b.tag == cdb.tag) begin
			next_entry.b.ready = 1'b1;
			next_entry.b.data = cdb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (take) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		entry <= next_entry;
	end

	assign busy = valid;
	assign fire = valid && entry.a.ready && entry.b.ready;
	assign payload = entry;
endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
	input logic clk,
	input logic reset,
	input logic alloc,
	input logic [ooo_pkg::reg_width-1:0] alloc_rd,
	input logic [ooo_pkg::reg_width-1:0] rs1,
	input logic [ooo_pkg::reg_width-1:0] rs2,
	output logic [ooo_pkg::tag_width-1:0] alloc_tag,
	output logic full,
	output ooo_pkg::operand_t src1,
	output ooo_pkg::operand_t src2,
	input ooo_pkg::cdb_t cdb,
	output logic commit_valid,
	output logic [ooo_pkg::reg_width-1:0] commit_rd,
	output logic [ooo_pkg::xlen-1:0] commit_data
);
	logic [ooo_pkg::tag_width-1:0] head;
	logic [ooo_pkg::tag_width-1:0] tail;
	logic [ooo_pkg::tag_width:0] count;
	logic done [ooo_pkg::rob_depth];
	logic [ooo_pkg::reg_width-1:0] dest [ooo_pkg::rob_depth];
	logic [ooo_pkg::xlen-1:0] value [ooo_pkg::rob_depth];
	logic pending [ooo_pkg::reg_count];
	logic [ooo_pkg::tag_width-1:0] rename [ooo_pkg::reg_count];
	logic [ooo_pkg::xlen-1:0] arf [ooo_pkg::reg_count];

	//////////////////////////////
	// operand read
	//////////////////////////////

	function automatic ooo_pkg::operand_t lookup(input logic [ooo_pkg::reg_width-1:0] r);
		ooo_pkg::operand_t o;
		logic [ooo_pkg::tag_width-1:0] t;
		t = rename[r];
		o.ready = 1'b1;
		o.tag = t;
		o.data = value[t];
		if (!pending[r]) begin
			o.data = arf[r];
		end else if (!done[t]) begin
			// result may be on the cdb right now
			o.ready = cdb.valid && cdb.tag == t;
			o.data = cdb.data;
		end
		return o;
	endfunction

	always_comb begin
		src1 = lookup(rs1);
		src2 = lookup(rs2);
	end

	//////////////////////////////
	// pointers and commit
	//////////////////////////////

	assign alloc_tag = tail;
	assign full = count == ooo_pkg::rob_depth;
	assign commit_valid = count != '0 && done[head];
	assign commit_rd = dest[head];
	assign commit_data = value[head];

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1;
			end
			if (commit_valid) begin
				head <= head + 1'b1;
			end
			if (alloc && !commit_valid) begin
				count <= count + 1'b1;
			end else if (!alloc && commit_valid) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			done[cdb.tag] <= 1'b1;
			value[cdb.tag] <= cdb.data;
		end
		if (alloc) begin
			done[tail] <= 1'b0;
			dest[tail] <= alloc_rd;
			rename[alloc_rd] <= tail;
		end
	end

	// new rename wins over a clear on the same register
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::reg_count; i++) begin
				pending[i] <= 1'b0;
				arf[i] <= '0;
			end
		end else begin
			if (commit_valid) begin
				arf[commit_rd] <= commit_data;
				if (rename[commit_rd] == head) begin
					pending[commit_rd] <= 1'b0;
				end
			end
			if (alloc) begin
				pending[alloc_rd] <= 1'b1;
			end
		end
	end
endmodule

// ==== rtl/result_if.sv ====
`timescale 1ns/1ps

interface result_if;
	logic valid;
	logic ready;
	logic [ooo_pkg::tag_width-1:0] tag;
	logic [ooo_pkg::xlen-1:0] data;

	modport unit (
		output valid,
		output tag,
		output data,
		input ready
	);

	modport arbiter (
		input valid,
		input tag,
		input data,
		output ready
	);
endinterface

// ==== rtl/shift_unit.sv ====
`timescale 1ns/1ps

module shift_unit (
	input logic clk,
	input logic reset,
	input logic load,
	input ooo_pkg::shift_payload_t load_payload,
	input ooo_pkg::cdb_t cdb,
	output logic busy,
	result_if.unit result
);
	ooo_pkg::shift_payload_t payload;
	logic fire;
	logic take;
	logic exec;
	logic done;
	logic left;
	logic [4:0] count;
	logic [ooo_pkg::tag_width-1:0] res_tag;
	logic [ooo_pkg::xlen-1:0] work;

	operand_station #(
		.payload_t(ooo_pkg::shift_payload_t)
	) station (
		.clk,
		.reset,
		.load,
		.load_payload,
		.cdb,
		.busy,
		.fire,
		.take,
		.payload
	);

	assign done = exec && count == '0;
	assign take = fire && (!exec || (done && result.ready));

	always_ff @(posedge clk) begin
		if (reset) begin
			exec <= 1'b0;
		end else if (take) begin
			exec <= 1'b1;
		end else if (done && result.ready) begin
			exec <= 1'b0;
		end
	end

	// one bit position per cycle until the count runs out
	always_ff @(posedge clk) begin
		if (take) begin
			work <= payload.a.data;
			count <= payload.b.data[4:0];
			left <= payload.left;
			res_tag <= payload.dst;
		end else if (exec && count != '0) begin
			work <= left ? work << 1 : work >> 1;
			count <= count - 1'b1;
		end
	end

	assign result.valid = done;
	assign result.tag = res_tag;
	assign result.data = work;
endmodule

// ==== verification/ooo_core_props.sv ====
`timescale 1ns/1ps

module ooo_core_props (
	input logic clk,
	input logic reset,
	input logic alu_valid,
	input logic alu_ready,
	input logic shift_valid,
	input logic shift_ready,
	input logic commit_valid
);
	// a result waits on the bus until granted
	alu_held: assert property (@(posedge clk) disable iff (reset)
		alu_valid && !alu_ready |=> alu_valid)
		else $error("alu result dropped without a grant");

	shift_held: assert property (@(posedge clk) disable iff (reset)
		shift_valid && !shift_ready |=> shift_valid)
		else $error("shift result dropped without a grant");

	// round robin hands the bus over when both units wait
	alu_then_shift: assert property (@(posedge clk) disable iff (reset)
		alu_ready && shift_valid |=> shift_ready)
		else $error("shift unit passed over after an alu grant");

	shift_then_alu: assert property (@(posedge clk) disable iff (reset)
		shift_ready && alu_valid |=> alu_ready)
		else $error("alu passed over after a shift grant");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !commit_valid)
		else $error("commit_valid high on the cycle after reset");
endmodule

bind cdb_arbiter ooo_core_props arbiter_props (
	.clk,
	.reset,
	.alu_valid(alu.valid),
	.alu_ready(alu.ready),
	.shift_valid(shift.valid),
	.shift_ready(shift.ready),
	.commit_valid(1'b0)
);

bind reorder_buffer ooo_core_props rob_props (
	.clk,
	.reset,
	.alu_valid(1'b0),
	.alu_ready(1'b0),
	.shift_valid(1'b0),
	.shift_ready(1'b0),
	.commit_valid
);

// ==== verification/ooo_core_tb.sv ====
`timescale 1ns/1ps

module ooo_core_tb;
	typedef logic [ooo_pkg::reg_width-1:0] reg_idx_t;
	typedef logic [ooo_pkg::xlen-1:0] data_t;

	// instructions issued by all tests together
	localparam int instr_total = 55;
	localparam int watchdog_cycles = instr_total * 40 + 200;

	logic clk;
	logic reset;
	logic issue_valid;
	ooo_pkg::op_t issue_op;
	reg_idx_t issue_rd;
	reg_idx_t issue_rs1;
	reg_idx_t issue_rs2;
	logic [15:0] issue_imm;
	logic issue_ready;
	logic commit_valid;
	reg_idx_t commit_rd;
	data_t commit_data;

	data_t model [ooo_pkg::reg_count];
	reg_idx_t exp_rd [$];
	data_t exp_data [$];
	logic [15:0] lfsr_state;
	string test_name;
	int test_count;
	int check_count;
	int error_count;
	int test_errors;
	int stall_count;

	ooo_core dut (
		.clk,
		.reset,
		.issue_valid,
		.issue_op,
		.issue_rd,
		.issue_rs1,
		.issue_rs2,
		.issue_imm,
		.issue_ready,
		.commit_valid,
		.commit_rd,
		.commit_data
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic data_t expected_result(input ooo_pkg::op_t op, input data_t a,
			input data_t b);
		case (op)
			ooo_pkg::op_sub: return a - b;
			ooo_pkg::op_sll: return a << b[4:0];
			ooo_pkg::op_srl: return a >> b[4:0];
			default: return a + b;
		endcase
	endfunction

	task automatic report_failure(input string msg);
		error_count++;
		$display("test %s failed: %s", test_name, msg);
	endtask

	task automatic compare_data(input string what, input data_t expected, input data_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic compare_reg(input string what, input reg_idx_t expected,
			input reg_idx_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	// model is updated in program order at issue time
	task automatic issue(input ooo_pkg::op_t op, input reg_idx_t rd, input reg_idx_t rs1,
			input reg_idx_t rs2, input logic [15:0] imm);
		data_t a;
		data_t b;
		data_t result;
		a = model[rs1];
		if (op == ooo_pkg::op_addi) begin
			b = {{(ooo_pkg::xlen-16){imm[15]}}, imm};
		end else begin
			b = model[rs2];
		end
		result = expected_result(op, a, b);
		model[rd] = result;
		exp_rd.push_back(rd);
		exp_data.push_back(result);

		@(negedge clk);
		issue_valid = 1'b1;
		issue_op = op;
		issue_rd = rd;
		issue_rs1 = rs1;
		issue_rs2 = rs2;
		issue_imm = imm;
		#1;
		while (issue_ready !== 1'b1) begin
			stall_count++;
			@(negedge clk);
			#1;
		end
		@(posedge clk);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = error_count;
		stall_count = 0;
	endtask

	task automatic finish_test();
		@(negedge clk);
		issue_valid = 1'b0;
		while (exp_rd.size() != 0) begin
			@(negedge clk);
		end
		test_count++;
		$display("%s finished with %0d errors", test_name, error_count - test_errors);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_reset_addi();
		logic [15:0] imm;
		start_test("reset_addi");
		#1;
		if (issue_ready !== 1'b0) begin
			report_failure("issue_ready high in the first cycle out of reset");
		end
		repeat (4) begin
			@(negedge clk);
			if (commit_valid !== 1'b0) begin
				report_failure("commit_valid high with nothing issued");
			end
		end
		for (int r = 1; r < ooo_pkg::reg_count; r++) begin
			imm = 16'(random_bits(16));
			issue(ooo_pkg::op_addi, reg_idx_t'(r), 3'd0, 3'd0, imm);
		end
		finish_test();
	endtask

	task automatic test_dependent_chain();
		reg_idx_t prev;
		reg_idx_t rd;
		ooo_pkg::op_t op;
		start_test("dependent_chain");
		prev = 3'd1;
		for (int i = 0; i < 10; i++) begin
			rd = reg_idx_t'(i % 7 + 1);
			op = random_bits(1) ? ooo_pkg::op_sub : ooo_pkg::op_add;
			issue(op, rd, prev, reg_idx_t'(random_bits(3)), 16'd0);
			prev = rd;
		end
		finish_test();
	endtask

	task automatic test_shift_order();
		logic [15:0] amount;
		ooo_pkg::op_t op;
		start_test("shift_order");
		for (int i = 0; i < 4; i++) begin
			amount = 16'(random_bits(5));
			issue(ooo_pkg::op_addi, 3'd7, 3'd0, 3'd0, amount);
			op = random_bits(1) ? ooo_pkg::op_sll : ooo_pkg::op_srl;
			issue(op, reg_idx_t'(i + 1), reg_idx_t'(random_bits(3) % 6 + 1), 3'd7, 16'd0);
		end
		// add finishes long before the shift but commits after it
		issue(ooo_pkg::op_addi, 3'd7, 3'd0, 3'd0, 16'd31);
		issue(ooo_pkg::op_sll, 3'd2, 3'd1, 3'd7, 16'd0);
		issue(ooo_pkg::op_add, 3'd3, 3'd4, 3'd5, 16'd0);
		finish_test();
	endtask

	task automatic test_shared_cdb();
		ooo_pkg::op_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		start_test("shared_cdb");
		for (int i = 0; i < 16; i++) begin
			case (random_bits(3) % 5)
				0: op = ooo_pkg::op_add;
				1: op = ooo_pkg::op_sub;
				2: op = ooo_pkg::op_addi;
				3: op = ooo_pkg::op_sll;
				default: op = ooo_pkg::op_srl;
			endcase
			rd = reg_idx_t'(random_bits(3) % 7 + 1);
			rs1 = reg_idx_t'(random_bits(3));
			rs2 = reg_idx_t'(random_bits(3));
			issue(op, rd, rs1, rs2, 16'(random_bits(16)));
		end
		finish_test();
	endtask

	task automatic test_back_pressure();
		start_test("back_pressure");
		issue(ooo_pkg::op_addi, 3'd7, 3'd0, 3'd0, 16'd31);
		issue(ooo_pkg::op_sll, 3'd1, 3'd2, 3'd7, 16'd0);
		for (int i = 0; i < 9; i++) begin
			issue(ooo_pkg::op_srl, reg_idx_t'(i % 4 + 3), 3'd2, 3'd7, 16'd0);
		end
		if (stall_count == 0) begin
			report_failure("issue_ready never dropped under back-pressure");
		end
		finish_test();
	endtask

	//////////////////////////////
	// commit monitor
	//////////////////////////////

	initial begin
		forever begin
			@(negedge clk);
			if (!reset && commit_valid === 1'b1) begin
				if (exp_rd.size() == 0) begin
					report_failure("commit seen with no instruction outstanding");
				end else begin
					compare_reg("commit rd", exp_rd.pop_front(), commit_rd);
					compare_data("commit data", exp_data.pop_front(), commit_data);
				end
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles in test %s", watchdog_cycles, test_name);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		lfsr_state = 16'd30645;
		test_name = "reset";
		test_count = 0;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		stall_count = 0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = ooo_pkg::op_add;
		issue_rd = '0;
		issue_rs1 = '0;
		issue_rs2 = '0;
		issue_imm = '0;
		for (int i = 0; i < ooo_pkg::reg_count; i++) begin
			model[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset_addi();
		test_dependent_chain();
		test_shift_order();
		test_shared_cdb();
		test_back_pressure();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end
endmodule
